// ==== rx_pkg.sv ====
package rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////////////////////////////////////////

    // one signed adc code, also used for the slicer threshold
    typedef logic signed [7:0] adc_code_t;

    // pi control word, same width as the cdr phase code
    typedef logic [8:0] pi_code_t;

    // pi range selector
    typedef logic [4:0] max_sel_t;

    // saturating prbs counters
    typedef logic [31:0] count_t;

    ////////////////////////////////////////////////////////////////////////////
    // constants
    ////////////////////////////////////////////////////////////////////////////

    // prbs7, taps at 7 and 6, generator seeded with all ones
    localparam int unsigned PRBS_ORDER = 7;

    // cycles from reset release until control-valid
    localparam int unsigned RESET_WAIT = 32;

    // receive-bit source
    typedef enum logic {
        SRC_ADC  = 1'b0,
        SRC_BIST = 1'b1
    } rx_src_e;

endpackage

// ==== rx_cfg_if.sv ====
`timescale 1ns/1ps

interface rx_cfg_if;
    import rx_pkg::*;

    // levels and strobes from the control block
    logic      ctl_valid;
    logic      chk_run;
    rx_src_e   src_sel;
    logic      inj_pulse;
    adc_code_t bit_level;

    modport ctrl (
        output ctl_valid,
        output chk_run,
        output src_sel,
        output inj_pulse,
        output bit_level
    );

    modport dp (
        input ctl_valid,
        input chk_run,
        input src_sel,
        input inj_pulse,
        input bit_level
    );

endinterface

// ==== rx_ctrl.sv ====
`timescale 1ns/1ps

module rx_ctrl (
    input  logic              clk_adc,
    input  logic              cdr_rstb,
    input  logic              prbs_run_i,
    input  logic              sel_bist_i,
    input  logic              inj_err_i,
    input  rx_pkg::adc_code_t bit_level_i,
    rx_cfg_if.ctrl            cfg,
    output logic              ctl_valid_o
);
    import rx_pkg::*;

    localparam int WAIT_W = $clog2(RESET_WAIT);

    logic [WAIT_W-1:0] wait_cnt;
    logic              ctl_valid_q;
    logic              inj_err_q;
    logic              inj_pulse_q;
    logic              chk_run_q;
    rx_src_e           src_sel_q;

    // wait counter saturates at its last value, ctl_valid follows one edge later
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            wait_cnt    <= '0;
            ctl_valid_q <= 1'b0;
        end else begin
            if (wait_cnt != WAIT_W'(RESET_WAIT - 1)) begin
                wait_cnt <= wait_cnt + 1'b1;
            end
            ctl_valid_q <= (wait_cnt == WAIT_W'(RESET_WAIT - 1));
        end
    end

    // inject edge detect, run gating and source select
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            inj_err_q   <= 1'b0;
            inj_pulse_q <= 1'b0;
            chk_run_q   <= 1'b0;
            src_sel_q   <= SRC_ADC;
        end else begin
            inj_err_q   <= inj_err_i;
            inj_pulse_q <= inj_err_i & ~inj_err_q;
            chk_run_q   <= prbs_run_i & ctl_valid_q;
            src_sel_q   <= sel_bist_i ? SRC_BIST : SRC_ADC;
        end
    end

    assign cfg.ctl_valid = ctl_valid_q;
    assign cfg.chk_run   = chk_run_q;
    assign cfg.src_sel   = src_sel_q;
    assign cfg.inj_pulse = inj_pulse_q;
    assign cfg.bit_level = bit_level_i;
    assign ctl_valid_o   = ctl_valid_q;

    // the generator flips exactly one bit per inject request
    assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        cfg.inj_pulse |=> !cfg.inj_pulse);

endmodule

// ==== rx_bit_select.sv ====
`timescale 1ns/1ps

module rx_bit_select #(
    parameter int num_lanes = 16
) (
    input  logic                                clk_adc,
    input  logic                                cdr_rstb,
    input  rx_pkg::adc_code_t [num_lanes-1:0]   adc_codes_i,
    input  logic [num_lanes-1:0]                bist_bits_i,
    rx_cfg_if.dp                                cfg,
    output logic [num_lanes-1:0]                rx_bits_o
);
    import rx_pkg::*;

    logic [num_lanes-1:0] sliced;

    ////////////////////////////////////////////////////////////////////////////
    // lane slicer
    ////////////////////////////////////////////////////////////////////////////

    // strictly above the threshold reads as a one
    always_comb begin
        for (int k = 0; k < num_lanes; k++) begin
            sliced[k] = ($signed(adc_codes_i[k]) > $signed(cfg.bit_level));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // source select
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            rx_bits_o <= '0;
        end else begin
            if (cfg.src_sel == SRC_BIST) begin
                rx_bits_o <= bist_bits_i;
            end else begin
                rx_bits_o <= sliced;
            end
        end
    end

endmodule

// ==== prbs_gen.sv ====
`timescale 1ns/1ps

module prbs_gen #(
    parameter int num_lanes = 16
) (
    input  logic                 clk_adc,
    input  logic                 cdr_rstb,
    rx_cfg_if.dp                 cfg,
    output logic [num_lanes-1:0] bist_bits_o
);
    import rx_pkg::*;

    // bit 0 holds the newest stream bit, the top bit the oldest
    logic [PRBS_ORDER-1:0] lfsr_q;
    logic [PRBS_ORDER-1:0] lfsr_walk;
    logic [num_lanes-1:0]  word;
    logic [num_lanes-1:0]  inj_mask;
    logic                  new_bit;

    // unroll num_lanes lfsr steps, lane 0 first
    always_comb begin
        lfsr_walk = lfsr_q;
        new_bit   = 1'b0;
        for (int k = 0; k < num_lanes; k++) begin
            new_bit   = lfsr_walk[PRBS_ORDER-1] ^ lfsr_walk[PRBS_ORDER-2];
            word[k]   = new_bit;
            lfsr_walk = {lfsr_walk[PRBS_ORDER-2:0], new_bit};
        end
    end

    // single error on the earliest lane only
    always_comb begin
        inj_mask    = '0;
        inj_mask[0] = cfg.inj_pulse;
    end

    // error goes into the output word only, lfsr keeps running clean
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            lfsr_q      <= '1;
            bist_bits_o <= '0;
        end else begin
            lfsr_q      <= lfsr_walk;
            bist_bits_o <= word ^ inj_mask;
        end
    end

endmodule

// ==== prbs_check.sv ====
`timescale 1ns/1ps

module prbs_check #(
    parameter int num_lanes = 16
) (
    input  logic                 clk_adc,
    input  logic                 cdr_rstb,
    input  logic [num_lanes-1:0] rx_bits_i,
    rx_cfg_if.dp                 cfg,
    output rx_pkg::count_t       err_count_o,
    output rx_pkg::count_t       total_count_o
);
    import rx_pkg::*;

    localparam int CNT_W = $clog2(num_lanes + 1);
    localparam int SUM_W = $bits(count_t) + 1;

    typedef enum logic [1:0] {
        CHK_IDLE,
        CHK_SEED,
        CHK_RUN
    } chk_state_e;

    chk_state_e                      state_q;
    chk_state_e                      state_d;
    // hist_q[0] is the oldest bit
    logic [PRBS_ORDER-1:0]           hist_q;
    logic [num_lanes+PRBS_ORDER-1:0] stream;
    logic [num_lanes-1:0]            bit_err;
    logic [CNT_W-1:0]                n_err;
    logic [SUM_W-1:0]                err_sum;
    logic [SUM_W-1:0]                tot_sum;

    assign stream = {rx_bits_i, hist_q};

    // each bit against the xor of the bits 7 and 6 positions earlier
    always_comb begin
        n_err = '0;
        for (int k = 0; k < num_lanes; k++) begin
            bit_err[k] = stream[k+PRBS_ORDER] ^ stream[k+1] ^ stream[k];
            n_err      = n_err + CNT_W'(bit_err[k]);
        end
    end

    assign err_sum = {1'b0, err_count_o} + SUM_W'(n_err);
    assign tot_sum = {1'b0, total_count_o} + SUM_W'(num_lanes);

    // state of the word being sampled at this edge
    always_comb begin
        case (state_q)
            CHK_IDLE: state_d = cfg.chk_run ? CHK_SEED : CHK_IDLE;
            CHK_SEED: state_d = cfg.chk_run ? CHK_RUN : CHK_IDLE;
            CHK_RUN:  state_d = cfg.chk_run ? CHK_RUN : CHK_IDLE;
            default:  state_d = CHK_IDLE;
        endcase
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q       <= CHK_IDLE;
            err_count_o   <= '0;
            total_count_o <= '0;
        end else begin
            state_q <= state_d;
            if (state_d == CHK_RUN) begin
                err_count_o   <= err_sum[SUM_W-1] ? '1 : err_sum[SUM_W-2:0];
                total_count_o <= tot_sum[SUM_W-1] ? '1 : tot_sum[SUM_W-2:0];
            end
        end
    end

    // last PRBS_ORDER bits carried over the word boundary
    always_ff @(posedge clk_adc) begin
        if (state_d != CHK_IDLE) begin
            hist_q <= stream[num_lanes+PRBS_ORDER-1:num_lanes];
        end
    end

    assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
        err_count_o <= total_count_o);

endmodule

// ==== pi_code_map.sv ====
`timescale 1ns/1ps

module pi_code_map #(
    parameter int num_pi_out = 4
) (
    input  logic                                clk_adc,
    input  logic                                cdr_rstb,
    input  rx_pkg::pi_code_t [num_pi_out-1:0]   pi_phase_i,
    input  rx_pkg::max_sel_t [num_pi_out-1:0]   pi_max_sel_i,
    input  rx_pkg::pi_code_t [num_pi_out-1:0]   pi_offset_i,
    rx_cfg_if.dp                                cfg,
    output rx_pkg::pi_code_t [num_pi_out-1:0]   pi_code_o
);
    import rx_pkg::*;

    // one spare bit so that 16 * 32 does not wrap before the minus one
    localparam int SW = $bits(pi_code_t) + 1;

    pi_code_t [num_pi_out-1:0] scale;
    pi_code_t [num_pi_out-1:0] mapped;

    for (genvar j = 0; j < num_pi_out; j++) begin : g_map
        logic [SW-1:0] scale_wide;

        // scale = 16 * (max_sel + 1) - 1
        assign scale_wide = ((SW'(pi_max_sel_i[j]) + SW'(1)) << 4) - SW'(1);
        assign scale[j]   = scale_wide[SW-2:0];
        assign mapped[j]  = (pi_phase_i[j] % scale[j]) + pi_offset_i[j];

        assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
            scale[j] != '0);
    end

    // pi codes stay parked at zero until control is valid
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            pi_code_o <= '0;
        end else begin
            pi_code_o <= cfg.ctl_valid ? mapped : '0;
        end
    end

endmodule

// ==== rx_test_core.sv ====
`timescale 1ns/1ps

module rx_test_core #(
    parameter int num_lanes  = 16,
    parameter int num_pi_out = 4
) (
    input  logic                                clk_adc,
    input  logic                                cdr_rstb,
    input  rx_pkg::adc_code_t [num_lanes-1:0]   adc_codes_i,
    input  logic                                prbs_run_i,
    input  logic                                sel_bist_i,
    input  logic                                inj_err_i,
    input  rx_pkg::adc_code_t                   bit_level_i,
    input  rx_pkg::pi_code_t [num_pi_out-1:0]   pi_phase_i,
    input  rx_pkg::max_sel_t [num_pi_out-1:0]   pi_max_sel_i,
    input  rx_pkg::pi_code_t [num_pi_out-1:0]   pi_offset_i,
    output logic                                ctl_valid_o,
    output rx_pkg::pi_code_t [num_pi_out-1:0]   pi_code_o,
    output rx_pkg::count_t                      err_count_o,
    output rx_pkg::count_t                      total_count_o
);

    rx_cfg_if cfg_bus ();

    logic [num_lanes-1:0] bist_bits;
    logic [num_lanes-1:0] rx_bits;

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    rx_ctrl ctrl_i (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .prbs_run_i  (prbs_run_i),
        .sel_bist_i  (sel_bist_i),
        .inj_err_i   (inj_err_i),
        .bit_level_i (bit_level_i),
        .cfg         (cfg_bus.ctrl),
        .ctl_valid_o (ctl_valid_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // bist path and checker
    ////////////////////////////////////////////////////////////////////////////

    prbs_gen #(.num_lanes(num_lanes)) prbs_gen_i (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .cfg         (cfg_bus.dp),
        .bist_bits_o (bist_bits)
    );

    rx_bit_select #(.num_lanes(num_lanes)) bit_sel_i (
        .clk_adc     (clk_adc),
        .cdr_rstb    (cdr_rstb),
        .adc_codes_i (adc_codes_i),
        .bist_bits_i (bist_bits),
        .cfg         (cfg_bus.dp),
        .rx_bits_o   (rx_bits)
    );

    prbs_check #(.num_lanes(num_lanes)) prbs_check_i (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .rx_bits_i     (rx_bits),
        .cfg           (cfg_bus.dp),
        .err_count_o   (err_count_o),
        .total_count_o (total_count_o)
    );

    // pi control codes for the analog core
    pi_code_map #(.num_pi_out(num_pi_out)) pi_map_i (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .pi_phase_i   (pi_phase_i),
        .pi_max_sel_i (pi_max_sel_i),
        .pi_offset_i  (pi_offset_i),
        .cfg          (cfg_bus.dp),
        .pi_code_o    (pi_code_o)
    );

endmodule

// ==== tb_rx_checker.sv ====
`timescale 1ns/1ps

module tb_rx_checker #(
    parameter int num_pi_out = 4
) (
    input  logic                              clk_adc,
    input  logic                              check_en_i,
    input  logic                              ctl_valid_i,
    input  rx_pkg::pi_code_t [num_pi_out-1:0] pi_code_i,
    input  rx_pkg::count_t                    err_count_i,
    input  rx_pkg::count_t                    total_count_i,
    input  logic                              exp_ctl_valid_i,
    input  rx_pkg::pi_code_t [num_pi_out-1:0] exp_pi_code_i,
    output int                                fail_count_o
);
    import rx_pkg::*;

    int n_checks    = 0;
    int n_fail      = 0;
    int n_tests     = 0;
    int test_checks = 0;
    int test_fail   = 0;

    assign fail_count_o = n_fail;

    task automatic compare(input string name, input longint got, input longint exp);
        n_checks++;
        test_checks++;
        if (got != exp) begin
            n_fail++;
            test_fail++;
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    ///////////////////////////////////////////////////////////////////////////
    // per-cycle compare
    ///////////////////////////////////////////////////////////////////////////

    // outputs still hold the values from the previous edge here
    always @(posedge clk_adc) begin
        if (check_en_i) begin
            compare("ctl_valid_o", longint'(ctl_valid_i), longint'(exp_ctl_valid_i));
            for (int j = 0; j < num_pi_out; j++) begin
                compare($sformatf("pi_code_o[%0d]", j),
                        longint'(pi_code_i[j]), longint'(exp_pi_code_i[j]));
            end
        end
    end

    ///////////////////////////////////////////////////////////////////////////
    // end of test compares and reporting
    ///////////////////////////////////////////////////////////////////////////

    task automatic check_counts(input count_t exp_err, input count_t exp_tot);
        compare("err_count_o", longint'(err_count_i), longint'(exp_err));
        compare("total_count_o", longint'(total_count_i), longint'(exp_tot));
    endtask

    task automatic end_test(input string name);
        n_tests++;
        if (test_fail == 0) begin
            $display("test %s: ok, %0d checks", name, test_checks);
        end else begin
            $display("test %s: %0d of %0d checks wrong", name, test_fail, test_checks);
        end
        test_checks = 0;
        test_fail   = 0;
    endtask

    task automatic report();
        $display("tests %0d, checks %0d, errors %0d", n_tests, n_checks, n_fail);
    endtask

endmodule

// ==== tb_rx_test_core.sv ====
`timescale 1ns/1ps

module tb_rx_test_core;
    import rx_pkg::*;

    localparam int NL = 16;
    localparam int NP = 4;

    // cycle budget of each test, the run is cut at four times the sum
    localparam int LEN_RESET = 45;
    localparam int LEN_BIST  = 210;
    localparam int LEN_INJ   = 100;
    localparam int LEN_ADC   = 130;
    localparam int LEN_PI    = 64;
    localparam int LEN_HOLD  = 120;
    localparam int CYCLE_LIMIT =
        4 * (LEN_RESET + LEN_BIST + LEN_INJ + LEN_ADC + LEN_PI + LEN_HOLD);

    logic               clk_adc;
    logic               cdr_rstb;
    adc_code_t [NL-1:0] adc_codes;
    logic               prbs_run;
    logic               sel_bist;
    logic               inj_err;
    adc_code_t          bit_level;
    pi_code_t [NP-1:0]  pi_phase;
    max_sel_t [NP-1:0]  pi_max_sel;
    pi_code_t [NP-1:0]  pi_offset;
    logic               ctl_valid;
    pi_code_t [NP-1:0]  pi_code;
    count_t             err_count;
    count_t             total_count;

    // expected values handed to the checker
    logic               check_en;
    logic               exp_ctl_valid;
    pi_code_t [NP-1:0]  exp_pi_code;
    count_t             exp_err;
    count_t             exp_tot;
    int                 fail_count;

    int cyc_since_rst;
    int run_len;
    int cycles = 0;

    rx_test_core #(.num_lanes(NL), .num_pi_out(NP)) dut (
        .clk_adc       (clk_adc),
        .cdr_rstb      (cdr_rstb),
        .adc_codes_i   (adc_codes),
        .prbs_run_i    (prbs_run),
        .sel_bist_i    (sel_bist),
        .inj_err_i     (inj_err),
        .bit_level_i   (bit_level),
        .pi_phase_i    (pi_phase),
        .pi_max_sel_i  (pi_max_sel),
        .pi_offset_i   (pi_offset),
        .ctl_valid_o   (ctl_valid),
        .pi_code_o     (pi_code),
        .err_count_o   (err_count),
        .total_count_o (total_count)
    );

    tb_rx_checker #(.num_pi_out(NP)) mon (
        .clk_adc         (clk_adc),
        .check_en_i      (check_en),
        .ctl_valid_i     (ctl_valid),
        .pi_code_i       (pi_code),
        .err_count_i     (err_count),
        .total_count_i   (total_count),
        .exp_ctl_valid_i (exp_ctl_valid),
        .exp_pi_code_i   (exp_pi_code),
        .fail_count_o    (fail_count)
    );

    always #50 clk_adc = ~clk_adc;

    always @(posedge clk_adc) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    ///////////////////////////////////////////////////////////////////////////
    // reference models
    ///////////////////////////////////////////////////////////////////////////

    // h[0] is the newest bit, h[5] six back, h[6] seven back
    function automatic logic [6:0] shift_in(input logic [6:0] h, input logic [NL-1:0] w);
        logic [6:0] s;
        s = h;
        for (int k = 0; k < NL; k++) begin
            s = {s[5:0], w[k]};
        end
        return s;
    endfunction

    // next word of the prbs7 stream, returned as {state, word}
    function automatic logic [NL+6:0] prbs7_word(input logic [6:0] h);
        logic [6:0]    s;
        logic [NL-1:0] w;
        s = h;
        for (int k = 0; k < NL; k++) begin
            w[k] = s[5] ^ s[6];
            s    = {s[5:0], w[k]};
        end
        return {s, w};
    endfunction

    // bits that differ from the xor of the bits 6 and 7 back
    function automatic int count_errs(input logic [6:0] h, input logic [NL-1:0] w);
        logic [6:0] s;
        int         n;
        s = h;
        n = 0;
        for (int k = 0; k < NL; k++) begin
            if (w[k] != (s[5] ^ s[6])) begin
                n++;
            end
            s = {s[5:0], w[k]};
        end
        return n;
    endfunction

    function automatic pi_code_t pi_map(input pi_code_t phase, input max_sel_t max_sel,
                                        input pi_code_t offset);
        int scale;
        scale = 16 * (int'(max_sel) + 1) - 1;
        return pi_code_t'((int'(phase) % scale + int'(offset)) % 512);
    endfunction

    ///////////////////////////////////////////////////////////////////////////
    // stimulus helpers
    ///////////////////////////////////////////////////////////////////////////

    task automatic drive_pi();
        for (int j = 0; j < NP; j++) begin
            pi_phase[j]   = pi_code_t'($urandom);
            pi_max_sel[j] = max_sel_t'($urandom);
            pi_offset[j]  = pi_code_t'($urandom);
        end
    endtask

    // one cycle, then expectations for the outputs after that rising edge
    task automatic tick();
        @(posedge clk_adc);
        @(negedge clk_adc);
        if (cdr_rstb) begin
            cyc_since_rst++;
            if (prbs_run) begin
                run_len++;
            end
        end
        for (int j = 0; j < NP; j++) begin
            exp_pi_code[j] = exp_ctl_valid ?
                pi_map(pi_phase[j], pi_max_sel[j], pi_offset[j]) : '0;
        end
        exp_ctl_valid = (cyc_since_rst >= int'(RESET_WAIT));
        drive_pi();
    endtask

    // first word of a run window only seeds the checker
    task automatic close_window();
        prbs_run = 1'b0;
        repeat (4) tick();
        if (run_len > 0) begin
            exp_tot += count_t'(NL * (run_len - 1));
        end
        run_len = 0;
    endtask

    task automatic inject_errors(input int n);
        for (int i = 0; i < n; i++) begin
            inj_err = 1'b1;
            tick();
            inj_err = 1'b0;
            repeat (1 + $urandom_range(4)) tick();
        end
    endtask

    ///////////////////////////////////////////////////////////////////////////
    // test sequence
    ///////////////////////////////////////////////////////////////////////////

    initial begin
        int            k_inj;
        int            lvl;
        logic [6:0]    gen_hist;
        logic [6:0]    chk_hist;
        logic [NL+6:0] step;
        logic [NL-1:0] sent;

        void'($urandom(32'h9259069e));
        clk_adc       = 1'b0;
        cdr_rstb      = 1'b0;
        prbs_run      = 1'b0;
        sel_bist      = 1'b1;
        inj_err       = 1'b0;
        bit_level     = '0;
        adc_codes     = '0;
        check_en      = 1'b0;
        exp_ctl_valid = 1'b0;
        exp_pi_code   = '0;
        exp_err       = '0;
        exp_tot       = '0;
        cyc_since_rst = 0;
        run_len       = 0;
        drive_pi();

        repeat (2) tick();
        cdr_rstb = 1'b1;
        check_en = 1'b1;

        // control-valid rises at the 32nd edge, pi codes parked before it
        repeat (40) tick();
        mon.end_test("reset wait");

        prbs_run = 1'b1;
        repeat (200) tick();
        close_window();
        mon.check_counts(exp_err, exp_tot);
        mon.end_test("bist clean");

        // each flipped lane 0 shows up three times in the error rule
        k_inj    = 4 + int'($urandom_range(8));
        prbs_run = 1'b1;
        repeat (10) tick();
        inject_errors(k_inj);
        repeat (10) tick();
        close_window();
        exp_err += count_t'(3 * k_inj);
        mon.check_counts(exp_err, exp_tot);
        mon.end_test("bist inject");

        // adc codes around a random threshold, some bits pushed across it
        sel_bist  = 1'b0;
        lvl       = int'($urandom_range(80)) - 40;
        bit_level = adc_code_t'(lvl);
        repeat (4) tick();
        gen_hist = 7'($urandom);
        if (gen_hist == '0) begin
            gen_hist = 7'h01;
        end
        chk_hist = '0;
        prbs_run = 1'b1;
        for (int w = 0; w < 120; w++) begin
            step     = prbs7_word(gen_hist);
            gen_hist = step[NL+6:NL];
            sent     = step[NL-1:0];
            for (int k = 0; k < NL; k++) begin
                if ($urandom_range(19) == 0) begin
                    sent[k] = ~sent[k];
                end
                if (sent[k]) begin
                    adc_codes[k] = adc_code_t'(lvl + int'($urandom_range(80, 1)));
                end else begin
                    adc_codes[k] = adc_code_t'(lvl - int'($urandom_range(80, 0)));
                end
            end
            if (w > 0) begin
                exp_err += count_t'(count_errs(chk_hist, sent));
            end
            chk_hist = shift_in(chk_hist, sent);
            tick();
        end
        close_window();
        mon.check_counts(exp_err, exp_tot);
        mon.end_test("adc stream");

        repeat (LEN_PI) tick();
        mon.end_test("pi map");

        // counters frozen once run is off
        sel_bist = 1'b1;
        repeat (4) tick();
        prbs_run = 1'b1;
        repeat (30) tick();
        close_window();
        mon.check_counts(exp_err, exp_tot);
        inject_errors(4 + int'($urandom_range(8)));
        repeat (4) tick();
        mon.check_counts(exp_err, exp_tot);
        mon.end_test("counter hold");

        repeat (2) tick();
        mon.report();
        if (fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
rx_pkg.sv
rx_cfg_if.sv
rx_ctrl.sv
rx_bit_select.sv
prbs_gen.sv
prbs_check.sv
pi_code_map.sv
rx_test_core.sv
tb_rx_checker.sv
tb_rx_test_core.sv

// ==== Makefile ====
TOP = tb_rx_test_core

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1; st=$$?; cat sim.log; exit $$st
	@if grep -q "Checks failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint sim clean
